//--- source/decode_pkg.sv
//////////////////////////////////////////////////////////////////////
// Shared types of the decode stage: widths, operation codes, structs
// Referenced by scoped names from the RTL and the testbench
//////////////////////////////////////////////////////////////////////

package decode_pkg;

    typedef logic [31:0] word_t;      // Data, pc and instruction word
    typedef logic [4:0]  reg_addr_t;
    typedef logic [11:0] csr_addr_t;
    typedef logic [4:0]  opcode_t;    // Instruction bits 6:2

    typedef enum logic [1:0] {
        MUL_OFF,
        MUL_ONLY,
        MUL_FULL
    } mul_ext_e;

    typedef enum logic [5:0] {
        NOP, INVALID,
        LUI, AUIPC, JAL, JALR,
        BEQ, BNE, BLT, BGE, BLTU, BGEU,
        LB, LH, LW, LBU, LHU,
        SB, SH, SW,
        ADD, SUB, SLL, SLT, SLTU, XOR, SRL, SRA, OR, AND,
        MUL, MULH, MULHSU, MULHU, DIV, DIVU, REM, REMU,
        ECALL, EBREAK, SRET, MRET, WFI,
        CSRRW, CSRRS, CSRRC, CSRRWI, CSRRSI, CSRRCI
    } op_e;

    typedef enum logic [2:0] {
        R_TYPE, I_TYPE, S_TYPE, B_TYPE, U_TYPE, J_TYPE
    } format_e;

    // Result bypass from a later stage
    typedef struct packed {
        logic      we;
        reg_addr_t rd;
        word_t     data;
    } fwd_src_t;

    typedef struct packed {
        logic illegal;
        logic misaligned;
        logic access_fault;
    } exc_flags_t;

    //////////////////////////////////////////////////////////////////////
    // Major opcodes
    //////////////////////////////////////////////////////////////////////
    localparam opcode_t OPC_LOAD     = 5'b00000;
    localparam opcode_t OPC_MISC_MEM = 5'b00011;
    localparam opcode_t OPC_OP_IMM   = 5'b00100;
    localparam opcode_t OPC_AUIPC    = 5'b00101;
    localparam opcode_t OPC_STORE    = 5'b01000;
    localparam opcode_t OPC_OP       = 5'b01100;
    localparam opcode_t OPC_LUI      = 5'b01101;
    localparam opcode_t OPC_BRANCH   = 5'b11000;
    localparam opcode_t OPC_JALR     = 5'b11001;
    localparam opcode_t OPC_JAL      = 5'b11011;
    localparam opcode_t OPC_SYSTEM   = 5'b11100;

endpackage

//--- source/instr_classifier.sv
//////////////////////////////////////////////////////////////////////
// Combinational RV32IM decoder: operation, format and memory flags
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ns

module instr_classifier #(
    parameter decode_pkg::mul_ext_e MUL_EXT = decode_pkg::MUL_FULL
) (
    input  decode_pkg::word_t   instruction_i,
    output decode_pkg::op_e     op_o,
    output decode_pkg::format_e format_o,
    output logic                is_load_o,
    output logic                is_store_o,
    output logic                illegal_o
);

    decode_pkg::opcode_t opcode;
    logic [2:0]          funct3;
    logic [6:0]          funct7;
    logic                mul_ok;
    logic                div_ok;

    decode_pkg::op_e op_branch, op_load, op_store, op_imm, op_reg, op_system;

    assign opcode = instruction_i[6:2];
    assign funct3 = instruction_i[14:12];
    assign funct7 = instruction_i[31:25];
    assign mul_ok = (MUL_EXT != decode_pkg::MUL_OFF);
    assign div_ok = (MUL_EXT == decode_pkg::MUL_FULL);

    //////////////////////////////////////////////////////////////////////
    // Per-group subdecoders
    //////////////////////////////////////////////////////////////////////
    always_comb begin
        case (funct3)
            3'b000:  op_branch = decode_pkg::BEQ;
            3'b001:  op_branch = decode_pkg::BNE;
            3'b100:  op_branch = decode_pkg::BLT;
            3'b101:  op_branch = decode_pkg::BGE;
            3'b110:  op_branch = decode_pkg::BLTU;
            3'b111:  op_branch = decode_pkg::BGEU;
            default: op_branch = decode_pkg::INVALID;
        endcase
        case (funct3)
            3'b000:  op_load = decode_pkg::LB;
            3'b001:  op_load = decode_pkg::LH;
            3'b010:  op_load = decode_pkg::LW;
            3'b100:  op_load = decode_pkg::LBU;
            3'b101:  op_load = decode_pkg::LHU;
            default: op_load = decode_pkg::INVALID;
        endcase
        case (funct3)
            3'b000:  op_store = decode_pkg::SB;
            3'b001:  op_store = decode_pkg::SH;
            3'b010:  op_store = decode_pkg::SW;
            default: op_store = decode_pkg::INVALID;
        endcase
    end

    always_comb begin
        case (funct3)
            3'b000:  op_imm = decode_pkg::ADD;
            3'b001:  op_imm = (funct7 == 7'b0) ? decode_pkg::SLL : decode_pkg::INVALID;
            3'b010:  op_imm = decode_pkg::SLT;
            3'b011:  op_imm = decode_pkg::SLTU;
            3'b100:  op_imm = decode_pkg::XOR;
            3'b101: begin                                  // Shift kind in funct7
                if (funct7 == 7'b0000000)
                    op_imm = decode_pkg::SRL;
                else if (funct7 == 7'b0100000)
                    op_imm = decode_pkg::SRA;
                else
                    op_imm = decode_pkg::INVALID;
            end
            3'b110:  op_imm = decode_pkg::OR;
            default: op_imm = decode_pkg::AND;
        endcase
    end

    always_comb begin
        case ({funct7, funct3})
            10'b0000000_000: op_reg = decode_pkg::ADD;
            10'b0100000_000: op_reg = decode_pkg::SUB;
            10'b0000000_001: op_reg = decode_pkg::SLL;
            10'b0000000_010: op_reg = decode_pkg::SLT;
            10'b0000000_011: op_reg = decode_pkg::SLTU;
            10'b0000000_100: op_reg = decode_pkg::XOR;
            10'b0000000_101: op_reg = decode_pkg::SRL;
            10'b0100000_101: op_reg = decode_pkg::SRA;
            10'b0000000_110: op_reg = decode_pkg::OR;
            10'b0000000_111: op_reg = decode_pkg::AND;
            10'b0000001_000: op_reg = mul_ok ? decode_pkg::MUL    : decode_pkg::INVALID;
            10'b0000001_001: op_reg = mul_ok ? decode_pkg::MULH   : decode_pkg::INVALID;
            10'b0000001_010: op_reg = mul_ok ? decode_pkg::MULHSU : decode_pkg::INVALID;
            10'b0000001_011: op_reg = mul_ok ? decode_pkg::MULHU  : decode_pkg::INVALID;
            10'b0000001_100: op_reg = div_ok ? decode_pkg::DIV    : decode_pkg::INVALID;
            10'b0000001_101: op_reg = div_ok ? decode_pkg::DIVU   : decode_pkg::INVALID;
            10'b0000001_110: op_reg = div_ok ? decode_pkg::REM    : decode_pkg::INVALID;
            10'b0000001_111: op_reg = div_ok ? decode_pkg::REMU   : decode_pkg::INVALID;
            default:         op_reg = decode_pkg::INVALID;
        endcase
    end

    always_comb begin
        op_system = decode_pkg::INVALID;
        case (funct3)
            3'b000: begin                  // Privileged ops need rs1 and rd zero
                if (instruction_i[19:7] == '0) begin
                    case (instruction_i[31:20])
                        12'h000: op_system = decode_pkg::ECALL;
                        12'h001: op_system = decode_pkg::EBREAK;
                        12'h102: op_system = decode_pkg::SRET;
                        12'h302: op_system = decode_pkg::MRET;
                        12'h105: op_system = decode_pkg::WFI;
                        default: op_system = decode_pkg::INVALID;
                    endcase
                end
            end
            3'b001:  op_system = decode_pkg::CSRRW;
            3'b010:  op_system = decode_pkg::CSRRS;
            3'b011:  op_system = decode_pkg::CSRRC;
            3'b101:  op_system = decode_pkg::CSRRWI;
            3'b110:  op_system = decode_pkg::CSRRSI;
            3'b111:  op_system = decode_pkg::CSRRCI;
            default: op_system = decode_pkg::INVALID;
        endcase
    end

    //////////////////////////////////////////////////////////////////////
    // Opcode selection and format
    //////////////////////////////////////////////////////////////////////
    always_comb begin
        format_o = decode_pkg::R_TYPE;
        case (opcode)
            decode_pkg::OPC_LUI: begin
                op_o     = decode_pkg::LUI;
                format_o = decode_pkg::U_TYPE;
            end
            decode_pkg::OPC_AUIPC: begin
                op_o     = decode_pkg::AUIPC;
                format_o = decode_pkg::U_TYPE;
            end
            decode_pkg::OPC_JAL: begin
                op_o     = decode_pkg::JAL;
                format_o = decode_pkg::J_TYPE;
            end
            decode_pkg::OPC_JALR: begin
                op_o     = decode_pkg::JALR;
                format_o = decode_pkg::I_TYPE;
            end
            decode_pkg::OPC_BRANCH: begin
                op_o     = op_branch;
                format_o = decode_pkg::B_TYPE;
            end
            decode_pkg::OPC_LOAD: begin
                op_o     = op_load;
                format_o = decode_pkg::I_TYPE;
            end
            decode_pkg::OPC_STORE: begin
                op_o     = op_store;
                format_o = decode_pkg::S_TYPE;
            end
            decode_pkg::OPC_OP_IMM: begin
                op_o     = op_imm;
                format_o = decode_pkg::I_TYPE;
            end
            decode_pkg::OPC_OP:       op_o = op_reg;
            decode_pkg::OPC_MISC_MEM: op_o = (funct3 == 3'b000) ? decode_pkg::NOP  // FENCE
                                                                : decode_pkg::INVALID;
            decode_pkg::OPC_SYSTEM:   op_o = op_system;
            default:                  op_o = decode_pkg::INVALID;
        endcase
    end

    assign is_load_o  = (opcode == decode_pkg::OPC_LOAD);
    assign is_store_o = (opcode == decode_pkg::OPC_STORE);
    assign illegal_o  = (instruction_i[1:0] != 2'b11) || (op_o == decode_pkg::INVALID);

endmodule

//--- source/imm_gen.sv
//////////////////////////////////////////////////////////////////////
// Immediate extraction, one of five layouts chosen by format
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ns

module imm_gen (
    input  decode_pkg::word_t   instruction_i,
    input  decode_pkg::format_e format_i,
    output decode_pkg::word_t   immediate_o
);

    decode_pkg::word_t imm_i, imm_s, imm_b, imm_u, imm_j;
    logic              sign;

    assign sign  = instruction_i[31];

    assign imm_i = {{20{sign}}, instruction_i[31:20]};
    assign imm_s = {{20{sign}}, instruction_i[31:25], instruction_i[11:7]};
    assign imm_b = {{19{sign}}, sign, instruction_i[7], instruction_i[30:25],
                    instruction_i[11:8], 1'b0};
    assign imm_u = {instruction_i[31:12], 12'h000};
    assign imm_j = {{11{sign}}, sign, instruction_i[19:12], instruction_i[20],
                    instruction_i[30:21], 1'b0};

    always_comb begin
        case (format_i)
            decode_pkg::I_TYPE: immediate_o = imm_i;
            decode_pkg::S_TYPE: immediate_o = imm_s;
            decode_pkg::B_TYPE: immediate_o = imm_b;
            decode_pkg::U_TYPE: immediate_o = imm_u;
            decode_pkg::J_TYPE: immediate_o = imm_j;
            default:            immediate_o = '0;    // R_TYPE has none
        endcase
    end

endmodule

//--- source/operand_select.sv
//////////////////////////////////////////////////////////////////////
// Operand forwarding from execute and retire, second operand mux
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ns

module operand_select (
    input  decode_pkg::reg_addr_t rs1_i,
    input  decode_pkg::reg_addr_t rs2_i,
    input  decode_pkg::word_t     rs1_read_i,
    input  decode_pkg::word_t     rs2_read_i,
    input  decode_pkg::word_t     immediate_i,
    input  decode_pkg::format_e   format_i,
    input  decode_pkg::fwd_src_t  exec_fwd_i,
    input  decode_pkg::fwd_src_t  retire_fwd_i,
    output decode_pkg::word_t     rs1_data_o,
    output decode_pkg::word_t     rs2_data_o,
    output decode_pkg::word_t     second_operand_o
);

    // Youngest result wins, then retire, then the bank
    function automatic decode_pkg::word_t pick(
        input decode_pkg::reg_addr_t rs,
        input decode_pkg::word_t     bank,
        input decode_pkg::fwd_src_t  exe,
        input decode_pkg::fwd_src_t  ret
    );
        if (exe.we && exe.rd == rs)
            return exe.data;
        else if (ret.we && ret.rd == rs)
            return ret.data;
        else
            return bank;
    endfunction

    assign rs1_data_o = pick(rs1_i, rs1_read_i, exec_fwd_i, retire_fwd_i);
    assign rs2_data_o = pick(rs2_i, rs2_read_i, exec_fwd_i, retire_fwd_i);

    always_comb begin
        case (format_i)
            decode_pkg::I_TYPE,
            decode_pkg::S_TYPE,
            decode_pkg::U_TYPE: second_operand_o = immediate_i;
            default:            second_operand_o = rs2_data_o;
        endcase
    end

endmodule

//--- source/hazard_unit.sv
//////////////////////////////////////////////////////////////////////
// Register and memory lock tracking, hazard and kill generation
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ns

module hazard_unit (
    input  logic                  clk,
    input  logic                  reset_n,
    input  logic                  enable_i,
    input  decode_pkg::reg_addr_t rs1_i,
    input  decode_pkg::reg_addr_t rs2_i,
    input  decode_pkg::reg_addr_t rd_i,
    input  decode_pkg::format_e   format_i,
    input  logic                  is_load_i,
    input  logic                  is_store_i,
    input  logic                  exception_i,
    input  logic                  jumping_i,
    input  logic                  ctx_switch_i,
    input  logic                  rollback_i,
    output logic                  hazard_o,
    output logic                  killed_o
);

    decode_pkg::reg_addr_t locked_reg;   // Destination of an outstanding load
    logic                  locked_mem;   // Store still in flight
    logic                  use_rs1;
    logic                  use_rs2;
    logic                  hazard_raw;

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            locked_reg <= '0;
            locked_mem <= 1'b0;
        end else if (enable_i) begin
            if (hazard_o || killed_o) begin  // Bubble carries no lock
                locked_reg <= '0;
                locked_mem <= 1'b0;
            end else begin
                locked_reg <= is_load_i ? rd_i : '0;
                locked_mem <= is_store_i;
            end
        end
    end

    assign use_rs1 = format_i inside {decode_pkg::R_TYPE, decode_pkg::I_TYPE,
                                      decode_pkg::S_TYPE, decode_pkg::B_TYPE};
    assign use_rs2 = format_i inside {decode_pkg::R_TYPE, decode_pkg::S_TYPE,
                                      decode_pkg::B_TYPE};

    assign hazard_raw = (locked_mem && is_load_i)
                     || (use_rs1 && locked_reg != '0 && locked_reg == rs1_i)
                     || (use_rs2 && locked_reg != '0 && locked_reg == rs2_i);

    assign killed_o = jumping_i || ctx_switch_i || rollback_i;
    assign hazard_o = hazard_raw && !killed_o && !exception_i;

    //////////////////////////////////////////////////////////////////////
    // Checks
    //////////////////////////////////////////////////////////////////////
    // A bubble releases the lock, so the repeated instruction goes next
    a_one_bubble_per_hazard: assert property (
        @(posedge clk) disable iff (!reset_n)
        (enable_i && hazard_o) |=> !hazard_o);

    // An enabled kill leaves nothing locked behind it
    a_lock_clear_after_kill: assert property (
        @(posedge clk) disable iff (!reset_n)
        (enable_i && killed_o) |=> (locked_reg == '0 && !locked_mem));

endmodule

//--- source/decode_stage.sv
//////////////////////////////////////////////////////////////////////
// Decode stage top: sub-unit wiring and the register toward execute
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ns

module decode_stage #(
    parameter decode_pkg::mul_ext_e MUL_EXT = decode_pkg::MUL_FULL
) (
    input  logic                   clk,
    input  logic                   reset_n,
    input  logic                   enable_i,
    input  decode_pkg::word_t      instruction_i,
    input  decode_pkg::word_t      pc_i,
    input  decode_pkg::word_t      rs1_data_i,
    input  decode_pkg::word_t      rs2_data_i,
    input  decode_pkg::fwd_src_t   exec_fwd_i,
    input  decode_pkg::fwd_src_t   retire_fwd_i,
    input  logic                   access_fault_i,
    input  logic                   jumping_i,
    input  logic                   ctx_switch_i,
    input  logic                   rollback_i,
    output decode_pkg::reg_addr_t  rs1_o,
    output decode_pkg::reg_addr_t  rs2_o,
    output decode_pkg::reg_addr_t  rd_o,
    output decode_pkg::csr_addr_t  csr_address_o,
    output decode_pkg::word_t      rs1_data_o,
    output decode_pkg::word_t      rs2_data_o,
    output decode_pkg::word_t      second_operand_o,
    output decode_pkg::word_t      pc_o,
    output decode_pkg::word_t      instruction_o,
    output decode_pkg::word_t      jump_target_o,
    output decode_pkg::op_e        op_o,
    output decode_pkg::exc_flags_t exc_o,
    output logic                   hazard_o,
    output logic                   killed_o
);

    decode_pkg::op_e        op;
    decode_pkg::format_e    format;
    decode_pkg::word_t      immediate, rs1_data, rs2_data, second_operand;
    decode_pkg::reg_addr_t  rd;
    decode_pkg::exc_flags_t exc;
    logic                   is_load, is_store, illegal, killed;

    assign rs1_o = instruction_i[19:15];   // Combinational bank read address
    assign rs2_o = instruction_i[24:20];
    assign rd    = instruction_i[11:7];

    instr_classifier #(.MUL_EXT(MUL_EXT)) u_classifier (
        .instruction_i(instruction_i), .op_o(op), .format_o(format),
        .is_load_o(is_load), .is_store_o(is_store), .illegal_o(illegal));

    imm_gen u_imm_gen (
        .instruction_i(instruction_i), .format_i(format), .immediate_o(immediate));

    operand_select u_operand_select (
        .rs1_i(rs1_o), .rs2_i(rs2_o), .rs1_read_i(rs1_data_i), .rs2_read_i(rs2_data_i),
        .immediate_i(immediate), .format_i(format),
        .exec_fwd_i(exec_fwd_i), .retire_fwd_i(retire_fwd_i),
        .rs1_data_o(rs1_data), .rs2_data_o(rs2_data), .second_operand_o(second_operand));

    assign exc.illegal      = illegal;
    assign exc.misaligned   = (pc_i[1:0] != 2'b00);   // Fetch is always word aligned
    assign exc.access_fault = access_fault_i;

    hazard_unit u_hazard (
        .clk(clk), .reset_n(reset_n), .enable_i(enable_i),
        .rs1_i(rs1_o), .rs2_i(rs2_o), .rd_i(rd), .format_i(format),
        .is_load_i(is_load), .is_store_i(is_store), .exception_i(|exc),
        .jumping_i(jumping_i), .ctx_switch_i(ctx_switch_i), .rollback_i(rollback_i),
        .hazard_o(hazard_o), .killed_o(killed));

    //////////////////////////////////////////////////////////////////////
    // Register toward execute, frozen while enable_i is low
    //////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            op_o             <= decode_pkg::NOP;
            rd_o             <= '0;
            csr_address_o    <= '0;
            rs1_data_o       <= '0;
            rs2_data_o       <= '0;
            second_operand_o <= '0;
            pc_o             <= '0;
            instruction_o    <= '0;
            jump_target_o    <= '0;
            exc_o            <= '0;
            killed_o         <= 1'b0;
        end else if (enable_i) begin
            op_o             <= (hazard_o || killed) ? decode_pkg::NOP : op;  // Bubble
            rd_o             <= rd;
            csr_address_o    <= instruction_i[31:20];
            rs1_data_o       <= rs1_data;
            rs2_data_o       <= rs2_data;
            second_operand_o <= second_operand;
            pc_o             <= pc_i;
            instruction_o    <= instruction_i;
            jump_target_o    <= pc_i + immediate;
            exc_o            <= exc;
            killed_o         <= killed;
        end
    end

    // First edge out of reset still shows the reset bubble
    a_nop_after_reset: assert property (
        @(posedge clk) $rose(reset_n) |-> op_o == decode_pkg::NOP);

endmodule

//--- include/decode_tb_table.svh
//////////////////////////////////////////////////////////////////////
// Decode stage test table, one row per clock, results one cycle later
// Included inside the testbench module
//////////////////////////////////////////////////////////////////////
`ifndef DECODE_TB_TABLE_SVH
`define DECODE_TB_TABLE_SVH

localparam int MAX_ROWS = 48;

// Which registered output a row compares besides op and status
typedef enum logic [3:0] {
    CK_OP, CK_RS1_VAL, CK_RS1_BANK, CK_SEC_VAL, CK_SEC_BANK,
    CK_TARGET, CK_CSR, CK_EXC, CK_HOLD
} check_e;

typedef struct packed {
    decode_pkg::word_t instr;
    decode_pkg::word_t pc;
    logic [4:0]        ctl;      // enable, jumping, ctx_switch, rollback, access_fault
    logic [11:0]       fwd;      // Execute {we, rd}, retire {we, rd}
    decode_pkg::op_e   op;
    logic              hazard;   // Combinational, same cycle
    logic [3:0]        status;   // killed, illegal, misaligned, access_fault
    check_e            chk;
    decode_pkg::word_t val;
} row_t;

localparam logic [4:0]  RUN   = 5'b10000;
localparam logic [4:0]  STALL = 5'b00000;
localparam logic [4:0]  KILL  = 5'b10010;   // Rollback
localparam logic [4:0]  FAULT = 5'b10001;
localparam logic [11:0] NOFWD = 12'h000;

localparam decode_pkg::word_t EXE_DATA = 32'hE0E0_0E0E;
localparam decode_pkg::word_t RET_DATA = 32'h7E7E_0707;

row_t tab[0:MAX_ROWS-1];
int   n_rows = 0;

task automatic add_row(
    input decode_pkg::word_t instr,
    input decode_pkg::word_t pc,
    input logic [4:0]        ctl,
    input logic [11:0]       fwd,
    input decode_pkg::op_e   op,
    input logic              hazard,
    input logic [3:0]        status,
    input check_e            chk,
    input decode_pkg::word_t val
);
    tab[n_rows] = {instr, pc, ctl, fwd, op, hazard, status, chk, val};
    n_rows++;
endtask

task fill_table;
    // Columns: instruction, pc, control, bypass, op, hazard, status, check, value
    add_row(32'h123450B7, 32'h100, RUN, NOFWD, decode_pkg::LUI, 0, 4'h0, CK_OP, 0);
    add_row(32'h008000EF, 32'h104, RUN, NOFWD, decode_pkg::JAL, 0, 4'h0, CK_TARGET, 32'h10C);
    add_row(32'h00208863, 32'h108, RUN, NOFWD, decode_pkg::BEQ, 0, 4'h0, CK_TARGET, 32'h118);
    add_row(32'h00412183, 32'h10C, RUN, NOFWD, decode_pkg::LW, 0, 4'h0, CK_OP, 0);
    add_row(32'h00412423, 32'h110, RUN, NOFWD, decode_pkg::SW, 0, 4'h0, CK_OP, 0);
    add_row(32'hFFD08293, 32'h114, RUN, NOFWD, decode_pkg::ADD, 0, 4'h0, CK_SEC_VAL, 32'hFFFFFFFD);
    add_row(32'h4040D313, 32'h118, RUN, NOFWD, decode_pkg::SRA, 0, 4'h0, CK_OP, 0);
    add_row(32'h402083B3, 32'h11C, RUN, NOFWD, decode_pkg::SUB, 0, 4'h0, CK_OP, 0);
    add_row(32'h00208433, 32'h120, RUN, NOFWD, decode_pkg::ADD, 0, 4'h0, CK_SEC_BANK, 0);
    add_row(32'h022084B3, 32'h124, RUN, NOFWD, decode_pkg::MUL, 0, 4'h0, CK_OP, 0);
    add_row(32'h0220C533, 32'h128, RUN, NOFWD, decode_pkg::DIV, 0, 4'h0, CK_OP, 0);
    add_row(32'h305095F3, 32'h12C, RUN, NOFWD, decode_pkg::CSRRW, 0, 4'h0, CK_CSR, 32'h305);
    add_row(32'h00000073, 32'h130, RUN, NOFWD, decode_pkg::ECALL, 0, 4'h0, CK_OP, 0);
    add_row(32'h0FF0000F, 32'h134, RUN, NOFWD, decode_pkg::NOP, 0, 4'h0, CK_OP, 0);  // FENCE
    add_row(32'hFE208CE3, 32'h200, RUN, NOFWD, decode_pkg::BEQ, 0, 4'h0, CK_TARGET, 32'h1F8);

    // ADDI x12,x13,1 under both bypasses, retire alone twice, then neither
    add_row(32'h00168613, 32'h204, RUN, {6'h2D,6'h2D}, decode_pkg::ADD, 0, 4'h0, CK_RS1_VAL, EXE_DATA);
    add_row(32'h00168613, 32'h208, RUN, {6'h2E,6'h2D}, decode_pkg::ADD, 0, 4'h0, CK_RS1_VAL, RET_DATA);
    add_row(32'h00168613, 32'h20C, RUN, {6'h0D,6'h2D}, decode_pkg::ADD, 0, 4'h0, CK_RS1_VAL, RET_DATA);
    add_row(32'h00168613, 32'h210, RUN, {6'h0D,6'h0D}, decode_pkg::ADD, 0, 4'h0, CK_RS1_BANK, 0);

    // Load-use on x5, bubble, then the same ADD again
    add_row(32'h00012283, 32'h214, RUN, NOFWD, decode_pkg::LW, 0, 4'h0, CK_OP, 0);
    add_row(32'h00128333, 32'h218, RUN, NOFWD, decode_pkg::NOP, 1, 4'h0, CK_OP, 0);
    add_row(32'h00128333, 32'h218, RUN, NOFWD, decode_pkg::ADD, 0, 4'h0, CK_OP, 0);

    // Kill over a locked x13, then stall
    add_row(32'h00012683, 32'h21C, RUN, NOFWD, decode_pkg::LW, 0, 4'h0, CK_OP, 0);
    add_row(32'h00168613, 32'h220, KILL, NOFWD, decode_pkg::NOP, 0, 4'h8, CK_OP, 0);
    add_row(32'h00168613, 32'h300, RUN, NOFWD, decode_pkg::ADD, 0, 4'h0, CK_OP, 0);
    add_row(32'h402083B3, 32'h304, STALL, NOFWD, decode_pkg::SUB, 0, 4'h0, CK_HOLD, 0);
    add_row(32'h00208433, 32'h304, RUN, NOFWD, decode_pkg::ADD, 0, 4'h0, CK_SEC_BANK, 0);

    // Exceptions with x7 locked by the load before each
    add_row(32'h00012383, 32'h308, RUN, NOFWD, decode_pkg::LW, 0, 4'h0, CK_OP, 0);
    add_row(32'h00038430, 32'h30C, RUN, NOFWD, decode_pkg::ADD, 0, 4'h4, CK_EXC, 0);
    add_row(32'h00012383, 32'h310, RUN, NOFWD, decode_pkg::LW, 0, 4'h0, CK_OP, 0);
    add_row(32'h00038433, 32'h312, RUN, NOFWD, decode_pkg::ADD, 0, 4'h2, CK_EXC, 0);
    add_row(32'h00012383, 32'h318, RUN, NOFWD, decode_pkg::LW, 0, 4'h0, CK_OP, 0);
    add_row(32'h00038433, 32'h31C, FAULT, NOFWD, decode_pkg::ADD, 0, 4'h1, CK_EXC, 0);
    add_row(32'h0FF0000F, 32'h320, RUN, NOFWD, decode_pkg::NOP, 0, 4'h0, CK_OP, 0);
endtask

`endif

//--- bench/decode_stage_tb.sv
//////////////////////////////////////////////////////////////////////
// Testbench for the decode stage, table driven, one row per clock
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ns

module decode_stage_tb;

    `include "decode_tb_table.svh"

    logic                   clk;
    logic                   reset_n;
    logic                   enable_i;
    decode_pkg::word_t      instruction_i, pc_i, rs1_data_i, rs2_data_i;
    decode_pkg::fwd_src_t   exec_fwd_i, retire_fwd_i;
    logic                   access_fault_i, jumping_i, ctx_switch_i, rollback_i;
    decode_pkg::reg_addr_t  rs1_o, rs2_o, rd_o;
    decode_pkg::csr_addr_t  csr_address_o;
    decode_pkg::word_t      rs1_data_o, rs2_data_o, second_operand_o;
    decode_pkg::word_t      pc_o, instruction_o, jump_target_o;
    decode_pkg::op_e        op_o;
    decode_pkg::exc_flags_t exc_o;
    logic                   hazard_o, killed_o;

    logic [218:0]           outs;      // Registered outputs, op_o on top
    logic [218:0]           snap;      // outs at the previous check
    decode_pkg::word_t      seed;
    decode_pkg::word_t      bank1_q[0:MAX_ROWS-1];
    decode_pkg::word_t      bank2_q[0:MAX_ROWS-1];
    int                     errors;
    int                     checks;
    int                     i;

    decode_stage #(.MUL_EXT(decode_pkg::MUL_FULL)) DUT (
        .clk(clk), .reset_n(reset_n), .enable_i(enable_i),
        .instruction_i(instruction_i), .pc_i(pc_i),
        .rs1_data_i(rs1_data_i), .rs2_data_i(rs2_data_i),
        .exec_fwd_i(exec_fwd_i), .retire_fwd_i(retire_fwd_i),
        .access_fault_i(access_fault_i), .jumping_i(jumping_i),
        .ctx_switch_i(ctx_switch_i), .rollback_i(rollback_i),
        .rs1_o(rs1_o), .rs2_o(rs2_o), .rd_o(rd_o), .csr_address_o(csr_address_o),
        .rs1_data_o(rs1_data_o), .rs2_data_o(rs2_data_o),
        .second_operand_o(second_operand_o), .pc_o(pc_o),
        .instruction_o(instruction_o), .jump_target_o(jump_target_o),
        .op_o(op_o), .exc_o(exc_o), .hazard_o(hazard_o), .killed_o(killed_o));

    always #50 clk = ~clk;

    assign outs = {op_o, rd_o, csr_address_o, rs1_data_o, rs2_data_o, second_operand_o,
                   pc_o, instruction_o, jump_target_o, exc_o, killed_o};

    function automatic decode_pkg::word_t lcg_next(input decode_pkg::word_t s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic expect_word(input string what, input decode_pkg::word_t got,
                               input decode_pkg::word_t exp, input int row);
        checks++;
        assert (got === exp) else begin
            errors++;
            $display("FAIL %0t: row %0d %s = %h, expected %h", $time, row, what, got, exp);
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // Row drive and registered checks
    //////////////////////////////////////////////////////////////////////
    task automatic drive_row(input int r);
        seed = lcg_next(seed);
        bank1_q[r] = seed;
        seed = lcg_next(seed);
        bank2_q[r] = seed;
        instruction_i <= tab[r].instr;
        pc_i          <= tab[r].pc;
        rs1_data_i    <= bank1_q[r];
        rs2_data_i    <= bank2_q[r];
        exec_fwd_i    <= {tab[r].fwd[11:6], EXE_DATA};
        retire_fwd_i  <= {tab[r].fwd[5:0], RET_DATA};
        {enable_i, jumping_i, ctx_switch_i, rollback_i, access_fault_i} <= tab[r].ctl;
    endtask

    task automatic check_row(input int r);
        row_t t;
        t = tab[r];
        if (t.chk == CK_HOLD) begin
            checks++;
            assert (outs === snap) else begin
                errors++;
                $display("FAIL %0t: row %0d outputs changed while enable_i was low", $time, r);
            end
        end else begin
            if (t.chk != CK_EXC)
                expect_word("op_o", op_o, t.op, r);
            expect_word("{killed_o, exc_o}", {killed_o, exc_o}, t.status, r);
            expect_word("pc_o", pc_o, t.pc, r);
            expect_word("instruction_o", instruction_o, t.instr, r);
            expect_word("rd_o", rd_o, t.instr[11:7], r);
            expect_word("rs2_data_o", rs2_data_o, bank2_q[r], r);  // No row bypasses rs2
            case (t.chk)
                CK_RS1_VAL:  expect_word("rs1_data_o", rs1_data_o, t.val, r);
                CK_RS1_BANK: expect_word("rs1_data_o", rs1_data_o, bank1_q[r], r);
                CK_SEC_VAL:  expect_word("second_operand_o", second_operand_o, t.val, r);
                CK_SEC_BANK: expect_word("second_operand_o", second_operand_o, bank2_q[r], r);
                CK_TARGET:   expect_word("jump_target_o", jump_target_o, t.val, r);
                CK_CSR:      expect_word("csr_address_o", csr_address_o, t.val, r);
                default: ;
            endcase
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // Main sequence
    //////////////////////////////////////////////////////////////////////
    initial begin
        clk            = 1'b0;
        reset_n        = 1'b0;
        enable_i       = 1'b0;
        instruction_i  = '0;
        pc_i           = '0;
        rs1_data_i     = '0;
        rs2_data_i     = '0;
        exec_fwd_i     = '0;
        retire_fwd_i   = '0;
        access_fault_i = 1'b0;
        jumping_i      = 1'b0;
        ctx_switch_i   = 1'b0;
        rollback_i     = 1'b0;
        seed           = 32'd62;
        errors         = 0;
        checks         = 0;
        fill_table();

        repeat (2) @(posedge clk);
        reset_n <= 1'b1;
        @(negedge clk);
        expect_word("op_o after reset", op_o, decode_pkg::NOP, -1);
        checks++;
        assert (outs[212:0] === '0) else begin
            errors++;
            $display("FAIL %0t: outputs not cleared by reset", $time);
        end
        snap = outs;

        // Row i drives now, row i-1 shows at the outputs
        for (i = 0; i <= n_rows; i++) begin
            @(posedge clk);
            if (i < n_rows)
                drive_row(i);
            else
                enable_i <= 1'b0;
            @(negedge clk);
            if (i < n_rows) begin
                expect_word("hazard_o", hazard_o, tab[i].hazard, i);
                expect_word("rs1_o", rs1_o, tab[i].instr[19:15], i);
                expect_word("rs2_o", rs2_o, tab[i].instr[24:20], i);
            end
            if (i > 0)
                check_row(i - 1);
            snap = outs;
        end

        $display("Rows: %0d  checks: %0d  errors: %0d", n_rows, checks, errors);
        if (errors == 0)
            $display("RESULT: PASS");
        else
            $display("RESULT: FAIL");
        $finish;
    end

    // Watchdog sized from the table length
    initial begin
        wait (n_rows > 0);
        #((n_rows + 10) * 100);
        $display("Timeout: the table did not finish in time, run stopped");
        $display("RESULT: FAIL");
        $finish;
    end

endmodule

//--- decode_stage.f
+incdir+include
source/decode_pkg.sv
source/instr_classifier.sv
source/imm_gen.sv
source/operand_select.sv
source/hazard_unit.sv
source/decode_stage.sv
bench/decode_stage_tb.sv
